//--- hw/busPkg.sv
`default_nettype none

package busPkg;

	localparam int addrWidth = 32;
	localparam int dataWidth = 32;
	localparam int strbWidth = 4;

	typedef logic [addrWidth-1:0] addr_t;
	typedef logic [dataWidth-1:0] data_t;
	typedef logic [strbWidth-1:0] strb_t;
	typedef logic [1:0] resp_t;

	localparam resp_t respOkay = 2'd0;
	localparam resp_t respSlvErr = 2'd2;
	localparam resp_t respDecErr = 2'd3;

	// Address map, limits inclusive
	localparam addr_t romBase = 32'h0000_0000;
	localparam addr_t romLimit = 32'h0000_3FFF;
	localparam addr_t sramBase = 32'h0001_0000;
	localparam addr_t sramLimit = 32'h0001_FFFF;
	localparam addr_t wdtBase = 32'h1001_0000;
	localparam addr_t wdtLimit = 32'h1001_00FF;

	typedef enum logic [1:0] {selRom, selSram, selWdt, selNone} slaveSel_t;

	// Watchdog register offsets
	localparam logic [7:0] wdtEnableOffset = 8'h00;
	localparam logic [7:0] wdtKickOffset = 8'h04;
	localparam logic [7:0] wdtPeriodOffset = 8'h08;
	localparam logic [7:0] wdtCountOffset = 8'h0C;

endpackage

`default_nettype wire

//--- hw/axiLink.sv
`default_nettype none

// Single-beat AXI-style link, no IDs and no bursts
interface axiLink;

	// Write address
	busPkg::addr_t awAddr;
	logic awValid;
	logic awReady;

	// Write data
	busPkg::data_t wData;
	busPkg::strb_t wStrb;
	logic wValid;
	logic wReady;

	// Write response
	busPkg::resp_t bResp;
	logic bValid;
	logic bReady;

	// Read address
	busPkg::addr_t arAddr;
	logic arValid;
	logic arReady;

	// Read data
	busPkg::data_t rData;
	busPkg::resp_t rResp;
	logic rValid;
	logic rReady;

	modport master (
		output awAddr, awValid, wData, wStrb, wValid, bReady, arAddr, arValid, rReady,
		input awReady, wReady, bResp, bValid, arReady, rData, rResp, rValid
	);

	modport slave (
		input awAddr, awValid, wData, wStrb, wValid, bReady, arAddr, arValid, rReady,
		output awReady, wReady, bResp, bValid, arReady, rData, rResp, rValid
	);

endinterface

`default_nettype wire

//--- hw/busCrossbar.sv
`default_nettype none

module busCrossbar (
	input logic clk,
	input logic rstN,
	input busPkg::addr_t awAddr,
	input logic awValid,
	output logic awReady,
	input busPkg::data_t wData,
	input busPkg::strb_t wStrb,
	input logic wValid,
	output logic wReady,
	output busPkg::resp_t bResp,
	output logic bValid,
	input logic bReady,
	input busPkg::addr_t arAddr,
	input logic arValid,
	output logic arReady,
	output busPkg::data_t rData,
	output busPkg::resp_t rResp,
	output logic rValid,
	input logic rReady,
	axiLink.master romLink,
	axiLink.master sramLink,
	axiLink.master wdtLink
);

	function automatic logic inRange(busPkg::addr_t addr, busPkg::addr_t base,
			busPkg::addr_t limit);
		// Wraps below base, so one compare covers both ends
		return (addr - base) <= (limit - base);
	endfunction

	function automatic busPkg::slaveSel_t decode(busPkg::addr_t addr);
		if (inRange(addr, busPkg::romBase, busPkg::romLimit))
			return busPkg::selRom;
		if (inRange(addr, busPkg::sramBase, busPkg::sramLimit))
			return busPkg::selSram;
		if (inRange(addr, busPkg::wdtBase, busPkg::wdtLimit))
			return busPkg::selWdt;
		return busPkg::selNone;
	endfunction

	busPkg::slaveSel_t awSel;
	busPkg::slaveSel_t arSel;
	busPkg::slaveSel_t wrTarget;
	busPkg::slaveSel_t rdTarget;
	logic wrPending;
	logic rdPending;
	logic errBValid;
	logic errRValid;
	logic awHs;
	logic arHs;

	assign awSel = decode(awAddr);
	assign arSel = decode(arAddr);
	assign awHs = awValid && awReady;
	assign arHs = arValid && arReady;

	// Payload fans out to every slave, only valids are steered
	assign romLink.awAddr = awAddr;
	assign romLink.wData = wData;
	assign romLink.wStrb = wStrb;
	assign romLink.arAddr = arAddr;
	assign sramLink.awAddr = awAddr;
	assign sramLink.wData = wData;
	assign sramLink.wStrb = wStrb;
	assign sramLink.arAddr = arAddr;
	assign wdtLink.awAddr = awAddr;
	assign wdtLink.wData = wData;
	assign wdtLink.wStrb = wStrb;
	assign wdtLink.arAddr = arAddr;

	assign romLink.awValid = awValid && !wrPending && awSel == busPkg::selRom;
	assign romLink.wValid = wValid && !wrPending && awSel == busPkg::selRom;
	assign romLink.arValid = arValid && !rdPending && arSel == busPkg::selRom;
	assign sramLink.awValid = awValid && !wrPending && awSel == busPkg::selSram;
	assign sramLink.wValid = wValid && !wrPending && awSel == busPkg::selSram;
	assign sramLink.arValid = arValid && !rdPending && arSel == busPkg::selSram;
	assign wdtLink.awValid = awValid && !wrPending && awSel == busPkg::selWdt;
	assign wdtLink.wValid = wValid && !wrPending && awSel == busPkg::selWdt;
	assign wdtLink.arValid = arValid && !rdPending && arSel == busPkg::selWdt;

	// Response readies follow the stored target
	assign romLink.bReady = bReady && wrTarget == busPkg::selRom;
	assign romLink.rReady = rReady && rdTarget == busPkg::selRom;
	assign sramLink.bReady = bReady && wrTarget == busPkg::selSram;
	assign sramLink.rReady = rReady && rdTarget == busPkg::selSram;
	assign wdtLink.bReady = bReady && wrTarget == busPkg::selWdt;
	assign wdtLink.rReady = rReady && rdTarget == busPkg::selWdt;

	// Address readies, the unmapped case accepts as soon as both valids are up
	always_comb begin
		awReady = awValid && wValid;
		wReady = awValid && wValid;
		arReady = arValid;
		case (awSel)
			busPkg::selRom: begin
				awReady = romLink.awReady;
				wReady = romLink.wReady;
			end
			busPkg::selSram: begin
				awReady = sramLink.awReady;
				wReady = sramLink.wReady;
			end
			busPkg::selWdt: begin
				awReady = wdtLink.awReady;
				wReady = wdtLink.wReady;
			end
			default: ;
		endcase
		case (arSel)
			busPkg::selRom: arReady = romLink.arReady;
			busPkg::selSram: arReady = sramLink.arReady;
			busPkg::selWdt: arReady = wdtLink.arReady;
			default: ;
		endcase
		if (wrPending) begin
			awReady = 1'b0;
			wReady = 1'b0;
		end
		if (rdPending)
			arReady = 1'b0;
	end

	// Response routing back to the master
	always_comb begin
		bValid = errBValid;
		bResp = busPkg::respDecErr;
		rValid = errRValid;
		rResp = busPkg::respDecErr;
		rData = '0;
		case (wrTarget)
			busPkg::selRom: begin
				bValid = romLink.bValid;
				bResp = romLink.bResp;
			end
			busPkg::selSram: begin
				bValid = sramLink.bValid;
				bResp = sramLink.bResp;
			end
			busPkg::selWdt: begin
				bValid = wdtLink.bValid;
				bResp = wdtLink.bResp;
			end
			default: ;
		endcase
		case (rdTarget)
			busPkg::selRom: begin
				rValid = romLink.rValid;
				rResp = romLink.rResp;
				rData = romLink.rData;
			end
			busPkg::selSram: begin
				rValid = sramLink.rValid;
				rResp = sramLink.rResp;
				rData = sramLink.rData;
			end
			busPkg::selWdt: begin
				rValid = wdtLink.rValid;
				rResp = wdtLink.rResp;
				rData = wdtLink.rData;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			wrPending <= 1'b0;
			wrTarget <= busPkg::selNone;
			errBValid <= 1'b0;
		end else if (awHs) begin
			wrPending <= 1'b1;
			wrTarget <= awSel;
			errBValid <= awSel == busPkg::selNone;
		end else if (bValid && bReady) begin
			wrPending <= 1'b0;
			errBValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			rdPending <= 1'b0;
			rdTarget <= busPkg::selNone;
			errRValid <= 1'b0;
		end else if (arHs) begin
			rdPending <= 1'b1;
			rdTarget <= arSel;
			errRValid <= arSel == busPkg::selNone;
		end else if (rValid && rReady) begin
			rdPending <= 1'b0;
			errRValid <= 1'b0;
		end
	end

	// Master must hold address valid and stable until accepted
	assert property (@(posedge clk) disable iff (!rstN)
		awValid && !awReady |=> awValid && $stable(awAddr));
	assert property (@(posedge clk) disable iff (!rstN)
		arValid && !arReady |=> arValid && $stable(arAddr));

	// Only one responder per direction at a time
	assert property (@(posedge clk) disable iff (!rstN)
		$onehot0({romLink.bValid, sramLink.bValid, wdtLink.bValid, errBValid}));
	assert property (@(posedge clk) disable iff (!rstN)
		$onehot0({romLink.rValid, sramLink.rValid, wdtLink.rValid, errRValid}));

endmodule

`default_nettype wire

//--- hw/sramSlave.sv
`default_nettype none

module sramSlave #(
	parameter int sramDepth = 1024
) (
	input logic clk,
	input logic rstN,
	axiLink.slave bus
);

	localparam int idxWidth = $clog2(sramDepth);

	busPkg::data_t mem [sramDepth];
	busPkg::addr_t wrIndex;
	busPkg::addr_t rdIndex;
	logic wrAccept;
	logic rdAccept;

	// Word index from the offset into the SRAM window
	assign wrIndex = (bus.awAddr - busPkg::sramBase) >> 2;
	assign rdIndex = (bus.arAddr - busPkg::sramBase) >> 2;

	// Write needs address and data together, one response in flight
	assign wrAccept = !bus.bValid && bus.awValid && bus.wValid;
	assign rdAccept = !bus.rValid && bus.arValid;

	assign bus.awReady = wrAccept;
	assign bus.wReady = wrAccept;
	assign bus.arReady = rdAccept;
	assign bus.bResp = busPkg::respOkay;
	assign bus.rResp = busPkg::respOkay;

	// Storage and read data
	always_ff @(posedge clk) begin
		if (wrAccept) begin
			for (int i = 0; i < busPkg::strbWidth; i++) begin
				if (bus.wStrb[i])
					mem[wrIndex[idxWidth-1:0]][8*i +: 8] <= bus.wData[8*i +: 8];
			end
		end
		if (rdAccept)
			bus.rData <= mem[rdIndex[idxWidth-1:0]];
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			bus.bValid <= 1'b0;
			bus.rValid <= 1'b0;
		end else begin
			if (wrAccept)
				bus.bValid <= 1'b1;
			else if (bus.bReady)
				bus.bValid <= 1'b0;
			if (rdAccept)
				bus.rValid <= 1'b1;
			else if (bus.rReady)
				bus.rValid <= 1'b0;
		end
	end

	// Decoded window is larger than the array
	assert property (@(posedge clk) disable iff (!rstN)
		(wrAccept -> wrIndex < sramDepth) && (rdAccept -> rdIndex < sramDepth));

endmodule

`default_nettype wire

//--- hw/romSlave.sv
`default_nettype none

module romSlave #(
	parameter int romAddrWidth = 12
) (
	input logic clk,
	input logic rstN,
	axiLink.slave bus,
	input busPkg::data_t romOut,
	output logic romRead,
	output logic romEnable,
	output logic [romAddrWidth-1:0] romAddress
);

	busPkg::addr_t rdOffset;
	logic rdBusy;
	logic rdAccept;
	logic wrAccept;

	assign rdOffset = bus.arAddr - busPkg::romBase;
	assign rdAccept = !rdBusy && bus.arValid;
	assign wrAccept = !bus.bValid && bus.awValid && bus.wValid;

	assign bus.arReady = rdAccept;
	assign bus.awReady = wrAccept;
	assign bus.wReady = wrAccept;
	assign bus.rResp = busPkg::respOkay;
	// Read-only device, writes are dropped
	assign bus.bResp = busPkg::respSlvErr;

	assign romRead = romEnable;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			rdBusy <= 1'b0;
			romEnable <= 1'b0;
			bus.rValid <= 1'b0;
			bus.bValid <= 1'b0;
		end else begin
			// One cycle strobe per accepted read
			romEnable <= rdAccept;
			if (rdAccept)
				rdBusy <= 1'b1;
			else if (bus.rValid && bus.rReady)
				rdBusy <= 1'b0;
			if (romEnable)
				bus.rValid <= 1'b1;
			else if (bus.rReady)
				bus.rValid <= 1'b0;
			if (wrAccept)
				bus.bValid <= 1'b1;
			else if (bus.bReady)
				bus.bValid <= 1'b0;
		end
	end

	// Word address out, ROM data back one edge later
	always_ff @(posedge clk) begin
		if (rdAccept)
			romAddress <= rdOffset[romAddrWidth+1:2];
		if (romEnable)
			bus.rData <= romOut;
	end

	assert property (@(posedge clk) disable iff (!rstN)
		romEnable |=> !romEnable);

endmodule

`default_nettype wire

//--- hw/watchdogSlave.sv
`default_nettype none

module watchdogSlave (
	input logic clk,
	input logic rstN,
	axiLink.slave bus,
	output logic wdtTimeout
);

	logic wdtEnable;
	busPkg::data_t period;
	busPkg::data_t count;
	logic [7:0] wrOffset;
	logic [7:0] rdOffset;
	logic wrAccept;
	logic rdAccept;
	logic reload;

	assign wrOffset = bus.awAddr[7:0];
	assign rdOffset = bus.arAddr[7:0];
	assign wrAccept = !bus.bValid && bus.awValid && bus.wValid;
	assign rdAccept = !bus.rValid && bus.arValid;

	assign bus.awReady = wrAccept;
	assign bus.wReady = wrAccept;
	assign bus.arReady = rdAccept;
	assign bus.bResp = busPkg::respOkay;
	assign bus.rResp = busPkg::respOkay;

	// Enable writes and any kick restart the countdown
	assign reload = wrAccept && (wrOffset == busPkg::wdtEnableOffset ||
		wrOffset == busPkg::wdtKickOffset);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			wdtEnable <= 1'b0;
			period <= '0;
			count <= '0;
			wdtTimeout <= 1'b0;
			bus.bValid <= 1'b0;
			bus.rValid <= 1'b0;
		end else begin
			if (wrAccept && wrOffset == busPkg::wdtEnableOffset)
				wdtEnable <= bus.wData[0];
			if (wrAccept && wrOffset == busPkg::wdtPeriodOffset)
				period <= bus.wData;
			if (reload)
				count <= period;
			else if (wdtEnable && count != '0)
				count <= count - 1'b1;
			// Sticky until kicked or disabled
			if (reload)
				wdtTimeout <= 1'b0;
			else if (wdtEnable && count == '0)
				wdtTimeout <= 1'b1;
			if (wrAccept)
				bus.bValid <= 1'b1;
			else if (bus.bReady)
				bus.bValid <= 1'b0;
			if (rdAccept)
				bus.rValid <= 1'b1;
			else if (bus.rReady)
				bus.rValid <= 1'b0;
		end
	end

	// Register readback, kick reads as zero
	always_ff @(posedge clk) begin
		if (rdAccept) begin
			case (rdOffset)
				busPkg::wdtEnableOffset: bus.rData <= busPkg::data_t'(wdtEnable);
				busPkg::wdtPeriodOffset: bus.rData <= period;
				busPkg::wdtCountOffset: bus.rData <= count;
				default: bus.rData <= '0;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (!rstN)
		!wdtEnable |-> !wdtTimeout);

endmodule

`default_nettype wire

//--- hw/socTop.sv
`default_nettype none

module socTop #(
	parameter int sramDepth = 1024,
	parameter int romAddrWidth = 12
) (
	input logic clk,
	input logic rstN,
	input busPkg::addr_t awAddr,
	input logic awValid,
	output logic awReady,
	input busPkg::data_t wData,
	input busPkg::strb_t wStrb,
	input logic wValid,
	output logic wReady,
	output busPkg::resp_t bResp,
	output logic bValid,
	input logic bReady,
	input busPkg::addr_t arAddr,
	input logic arValid,
	output logic arReady,
	output busPkg::data_t rData,
	output busPkg::resp_t rResp,
	output logic rValid,
	input logic rReady,
	input busPkg::data_t romOut,
	output logic romRead,
	output logic romEnable,
	output logic [romAddrWidth-1:0] romAddress,
	output logic wdtTimeout
);

	axiLink romLink ();
	axiLink sramLink ();
	axiLink wdtLink ();

	busCrossbar xbar (
		.clk(clk),
		.rstN(rstN),
		.awAddr(awAddr),
		.awValid(awValid),
		.awReady(awReady),
		.wData(wData),
		.wStrb(wStrb),
		.wValid(wValid),
		.wReady(wReady),
		.bResp(bResp),
		.bValid(bValid),
		.bReady(bReady),
		.arAddr(arAddr),
		.arValid(arValid),
		.arReady(arReady),
		.rData(rData),
		.rResp(rResp),
		.rValid(rValid),
		.rReady(rReady),
		.romLink(romLink.master),
		.sramLink(sramLink.master),
		.wdtLink(wdtLink.master)
	);

	sramSlave #(
		.sramDepth(sramDepth)
	) sram (
		.clk(clk),
		.rstN(rstN),
		.bus(sramLink.slave)
	);

	romSlave #(
		.romAddrWidth(romAddrWidth)
	) rom (
		.clk(clk),
		.rstN(rstN),
		.bus(romLink.slave),
		.romOut(romOut),
		.romRead(romRead),
		.romEnable(romEnable),
		.romAddress(romAddress)
	);

	watchdogSlave wdt (
		.clk(clk),
		.rstN(rstN),
		.bus(wdtLink.slave),
		.wdtTimeout(wdtTimeout)
	);

endmodule

`default_nettype wire

//--- verif/socTests.svh
`ifndef SOC_TESTS_SVH
`define SOC_TESTS_SVH

function automatic busPkg::data_t mergeBytes(busPkg::data_t oldWord,
		busPkg::data_t newWord, busPkg::strb_t strb);
	busPkg::data_t result;
	result = oldWord;
	for (int i = 0; i < 4; i++) begin
		if (strb[i])
			result[8*i +: 8] = newWord[8*i +: 8];
	end
	return result;
endfunction

// Expected ROM word, 12-bit word address XOR the tag
function automatic busPkg::data_t romWord(busPkg::addr_t addr);
	busPkg::addr_t wordAddr;
	wordAddr = ((addr - busPkg::romBase) >> 2) & 32'h0000_0FFF;
	return wordAddr ^ 32'hA5A5_0000;
endfunction

task automatic testSramWords();
	busPkg::addr_t addrs [4];
	busPkg::data_t words [4];
	busPkg::data_t rd;
	busPkg::resp_t resp;
	addrs[0] = busPkg::sramBase;
	addrs[1] = busPkg::sramBase + 32'h4;
	addrs[2] = busPkg::sramBase + 32'h100;
	// Last word of the array
	addrs[3] = busPkg::sramBase + 32'hFFC;
	for (int i = 0; i < 4; i++) begin
		words[i] = $random(seed);
		busWrite(addrs[i], words[i], 4'hF, 0, resp);
		checkEq(32'(resp), 32'(busPkg::respOkay), "SRAM write response");
	end
	for (int i = 0; i < 4; i++) begin
		busRead(addrs[i], 0, rd, resp);
		checkEq(rd, words[i], "SRAM read data");
		checkEq(32'(resp), 32'(busPkg::respOkay), "SRAM read response");
	end
endtask

task automatic testSramStrobes();
	busPkg::addr_t addr;
	busPkg::data_t expected;
	busPkg::data_t newWord;
	busPkg::data_t rd;
	busPkg::resp_t resp;
	busPkg::strb_t strbs [3];
	addr = busPkg::sramBase + 32'h200;
	strbs[0] = 4'b0101;
	strbs[1] = 4'b1000;
	strbs[2] = 4'b0010;
	expected = $random(seed);
	busWrite(addr, expected, 4'hF, 0, resp);
	for (int i = 0; i < 3; i++) begin
		newWord = $random(seed);
		busWrite(addr, newWord, strbs[i], 0, resp);
		checkEq(32'(resp), 32'(busPkg::respOkay), "SRAM strobe write response");
		expected = mergeBytes(expected, newWord, strbs[i]);
		busRead(addr, 0, rd, resp);
		checkEq(rd, expected, "SRAM partial strobe merge");
	end
endtask

task automatic testRomReads();
	busPkg::addr_t addrs [4];
	busPkg::data_t rd;
	busPkg::resp_t resp;
	int pulsesBefore;
	addrs[0] = busPkg::romBase;
	addrs[1] = busPkg::romBase + 32'h4;
	addrs[2] = busPkg::romBase + 32'h1234;
	addrs[3] = busPkg::romLimit - 32'h3;
	for (int i = 0; i < 4; i++) begin
		pulsesBefore = romPulses;
		busRead(addrs[i], 0, rd, resp);
		checkEq(rd, romWord(addrs[i]), "ROM read data");
		checkEq(32'(resp), 32'(busPkg::respOkay), "ROM read response");
		// One enable cycle per ROM access
		checkEq(32'(romPulses - pulsesBefore), 32'd1, "romEnable cycles per read");
	end
	pulsesBefore = romPulses;
	busWrite(busPkg::romBase + 32'h8, $random(seed), 4'hF, 0, resp);
	checkEq(32'(resp), 32'(busPkg::respSlvErr), "ROM write response");
	checkEq(32'(romPulses - pulsesBefore), 32'd0, "romEnable raised by a write");
	busRead(busPkg::romBase + 32'h8, 0, rd, resp);
	checkEq(rd, romWord(busPkg::romBase + 32'h8), "ROM data after write");
endtask

task automatic testUnmapped();
	busPkg::addr_t addrs [3];
	busPkg::data_t rd;
	busPkg::resp_t resp;
	// Gap after ROM, far region, just past the watchdog window
	addrs[0] = 32'h0000_4000;
	addrs[1] = 32'h2000_0000;
	addrs[2] = busPkg::wdtLimit + 32'h1;
	for (int i = 0; i < 3; i++) begin
		busWrite(addrs[i], 32'hDEAD_BEEF, 4'hF, 0, resp);
		checkEq(32'(resp), 32'(busPkg::respDecErr), "unmapped write response");
		busRead(addrs[i], 0, rd, resp);
		checkEq(32'(resp), 32'(busPkg::respDecErr), "unmapped read response");
		checkEq(rd, 32'h0, "unmapped read data");
	end
endtask

task automatic testWatchdog();
	busPkg::addr_t enableAddr;
	busPkg::addr_t kickAddr;
	busPkg::addr_t periodAddr;
	busPkg::addr_t countAddr;
	busPkg::data_t rd;
	busPkg::resp_t resp;
	int waited;
	enableAddr = busPkg::wdtBase + 32'(busPkg::wdtEnableOffset);
	kickAddr = busPkg::wdtBase + 32'(busPkg::wdtKickOffset);
	periodAddr = busPkg::wdtBase + 32'(busPkg::wdtPeriodOffset);
	countAddr = busPkg::wdtBase + 32'(busPkg::wdtCountOffset);
	busWrite(periodAddr, 32'd50, 4'hF, 0, resp);
	checkEq(32'(resp), 32'(busPkg::respOkay), "watchdog period write response");
	busRead(periodAddr, 0, rd, resp);
	checkEq(rd, 32'd50, "watchdog period readback");
	busWrite(enableAddr, 32'd1, 4'hF, 0, resp);
	// Kick every 20 cycles for 300 cycles
	repeat (15) begin
		repeat (20) begin
			@(negedge clk);
			checkEq(32'(wdtTimeout), 32'd0, "wdtTimeout high although kicked");
		end
		busWrite(kickAddr, 32'd0, 4'hF, 0, resp);
	end
	busRead(countAddr, 0, rd, resp);
	checkEq(32'(rd <= 32'd50), 32'd1, "watchdog count above period");
	busRead(kickAddr, 0, rd, resp);
	checkEq(rd, 32'h0, "watchdog kick register read");
	// Countdown restarts here so the wait is measured from a reload
	busWrite(kickAddr, 32'd0, 4'hF, 0, resp);
	waited = 0;
	while (!wdtTimeout && waited < 60) begin
		@(negedge clk);
		waited++;
	end
	checkEq(32'(wdtTimeout), 32'd1, "wdtTimeout did not rise within 60 cycles");
	busWrite(kickAddr, 32'd0, 4'hF, 0, resp);
	checkEq(32'(wdtTimeout), 32'd0, "kick did not clear wdtTimeout");
	busWrite(enableAddr, 32'd0, 4'hF, 0, resp);
	busRead(enableAddr, 0, rd, resp);
	checkEq(rd, 32'h0, "watchdog still enabled");
endtask

task automatic testBackPressure();
	busPkg::addr_t addr;
	busPkg::data_t word;
	busPkg::data_t rd;
	busPkg::resp_t resp;
	addr = busPkg::sramBase + 32'h300;
	word = $random(seed);
	busWrite(addr, word, 4'hF, 10, resp);
	checkEq(32'(resp), 32'(busPkg::respOkay), "stalled SRAM write response");
	busRead(addr, 10, rd, resp);
	checkEq(rd, word, "stalled SRAM read data");
	busRead(busPkg::romBase + 32'h40, 10, rd, resp);
	checkEq(rd, romWord(busPkg::romBase + 32'h40), "stalled ROM read data");
	busRead(32'h3000_0000, 10, rd, resp);
	checkEq(32'(resp), 32'(busPkg::respDecErr), "stalled unmapped read response");
	busWrite(32'h3000_0000, word, 4'hF, 10, resp);
	checkEq(32'(resp), 32'(busPkg::respDecErr), "stalled unmapped write response");
endtask

`endif

//--- verif/socTb.sv
`default_nettype none

module socTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int resetCycles = 8;
	localparam int numTests = 6;
	localparam int cyclesPerTest = 200;
	localparam int maxWdtPeriod = 50;
	localparam int timeoutCycles = resetCycles + numTests * cyclesPerTest + maxWdtPeriod;

	logic clk = 1'b0;
	logic rstN;
	busPkg::addr_t awAddr;
	logic awValid;
	logic awReady;
	busPkg::data_t wData;
	busPkg::strb_t wStrb;
	logic wValid;
	logic wReady;
	busPkg::resp_t bResp;
	logic bValid;
	logic bReady;
	busPkg::addr_t arAddr;
	logic arValid;
	logic arReady;
	busPkg::data_t rData;
	busPkg::resp_t rResp;
	logic rValid;
	logic rReady;
	busPkg::data_t romOut;
	logic romRead;
	logic romEnable;
	logic [11:0] romAddress;
	logic wdtTimeout;
	integer seed = 32'h606d;
	int romPulses = 0;

	always #5 clk = ~clk;

	socTop #(
		.sramDepth(1024),
		.romAddrWidth(12)
	) uut (
		.clk(clk),
		.rstN(rstN),
		.awAddr(awAddr),
		.awValid(awValid),
		.awReady(awReady),
		.wData(wData),
		.wStrb(wStrb),
		.wValid(wValid),
		.wReady(wReady),
		.bResp(bResp),
		.bValid(bValid),
		.bReady(bReady),
		.arAddr(arAddr),
		.arValid(arValid),
		.arReady(arReady),
		.rData(rData),
		.rResp(rResp),
		.rValid(rValid),
		.rReady(rReady),
		.romOut(romOut),
		.romRead(romRead),
		.romEnable(romEnable),
		.romAddress(romAddress),
		.wdtTimeout(wdtTimeout)
	);

	// Asynchronous external ROM, word address XOR a fixed tag
	assign romOut = romRead ? ({20'h0, romAddress} ^ 32'hA5A5_0000) : 32'h0;

	task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("[ERROR] %0t: %s (got 0x%08h, expected 0x%08h)", $time, msg,
				actual, expected);
			$display("TB FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// ROM pins, read strobe follows enable and each high cycle is counted
	always @(negedge clk) begin
		if (rstN === 1'b1) begin
			checkEq(32'(romRead), 32'(romEnable), "romRead differs from romEnable");
			if (romEnable)
				romPulses++;
		end
	end

	// Single write; stall keeps bReady low that many cycles after bValid
	task automatic busWrite(input busPkg::addr_t addr, input busPkg::data_t data,
			input busPkg::strb_t strb, input int stall, output busPkg::resp_t resp);
		@(posedge clk);
		awAddr <= addr;
		awValid <= 1'b1;
		wData <= data;
		wStrb <= strb;
		wValid <= 1'b1;
		do @(negedge clk); while (!(awReady && wReady));
		@(posedge clk);
		awValid <= 1'b0;
		wValid <= 1'b0;
		do @(negedge clk); while (!bValid);
		resp = bResp;
		repeat (stall) begin
			@(negedge clk);
			checkEq(32'(bValid), 32'd1, "bValid dropped while bReady low");
			checkEq(32'(bResp), 32'(resp), "bResp changed while bReady low");
		end
		@(posedge clk);
		bReady <= 1'b1;
		@(posedge clk);
		bReady <= 1'b0;
		@(negedge clk);
		checkEq(32'(bValid), 32'd0, "bValid still high after write response");
	endtask

	task automatic busRead(input busPkg::addr_t addr, input int stall,
			output busPkg::data_t data, output busPkg::resp_t resp);
		@(posedge clk);
		arAddr <= addr;
		arValid <= 1'b1;
		do @(negedge clk); while (!arReady);
		@(posedge clk);
		arValid <= 1'b0;
		do @(negedge clk); while (!rValid);
		data = rData;
		resp = rResp;
		repeat (stall) begin
			@(negedge clk);
			checkEq(32'(rValid), 32'd1, "rValid dropped while rReady low");
			checkEq(rData, data, "rData changed while rReady low");
			checkEq(32'(rResp), 32'(resp), "rResp changed while rReady low");
		end
		@(posedge clk);
		rReady <= 1'b1;
		@(posedge clk);
		rReady <= 1'b0;
		@(negedge clk);
		checkEq(32'(rValid), 32'd0, "rValid still high after read response");
	endtask

	`include "socTests.svh"

	initial begin
		rstN = 1'b0;
		awAddr = '0;
		awValid = 1'b0;
		wData = '0;
		wStrb = '0;
		wValid = 1'b0;
		bReady = 1'b0;
		arAddr = '0;
		arValid = 1'b0;
		rReady = 1'b0;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
		testSramWords();
		testSramStrobes();
		testRomReads();
		testUnmapped();
		testWatchdog();
		testBackPressure();
		@(posedge clk);
		$display("TB PASSED");
		$finish;
	end

	initial begin
		repeat (timeoutCycles) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d clock cycles", timeoutCycles);
		$display("TB FAILED");
		$fatal(1, "simulation timeout");
	end

endmodule

`default_nettype wire

//--- soc.f
+incdir+verif
hw/busPkg.sv
hw/axiLink.sv
hw/busCrossbar.sv
hw/sramSlave.sv
hw/romSlave.sv
hw/watchdogSlave.sv
hw/socTop.sv
verif/socTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module socTb -f soc.f -o socSim

./obj_dir/socSim
